/* source/packer_pkg.sv */
package packer_pkg;

   // byte in, word out
   localparam int BYTE_W         = 8;
   localparam int WORD_W         = 32;
   localparam int BYTES_PER_WORD = WORD_W / BYTE_W;

   // fifo is addressed in bytes
   localparam int ADDR_W    = 6;
   localparam int DEPTH     = 1 << ADDR_W;
   localparam int RD_ADDR_W = ADDR_W - $clog2(BYTES_PER_WORD);

   // burst limits
   localparam int BURST_WORDS = 4;
   localparam int BURST_BYTES = BURST_WORDS * BYTES_PER_WORD;
   localparam int BURST_CNT_W = $clog2(BURST_WORDS + 1);

   typedef logic [BYTE_W-1:0]      byte_t;
   typedef logic [WORD_W-1:0]      word_t;
   typedef logic [ADDR_W:0]        level_t;
   typedef logic [BURST_CNT_W-1:0] burst_cnt_t;

   // one output beat, last marks the end of a burst
   typedef struct packed {
      word_t data;
      logic  last;
   } out_beat_t;

endpackage

/* source/asym_ram_2p.sv */
module asym_ram_2p #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W   = 6
) (
   input  logic                                           clk,
   input  logic                                           w_en,
   input  logic [ADDR_W-1:0]                              w_addr,
   input  logic [W_DATA_W-1:0]                            w_data,
   input  logic                                           r_en,
   input  logic [ADDR_W-$clog2(R_DATA_W/W_DATA_W)-1:0]    r_addr,
   output logic [R_DATA_W-1:0]                            r_data
);

   // lanes per wide row and the row count
   localparam int RATIO    = R_DATA_W / W_DATA_W;
   localparam int LANE_W   = $clog2(RATIO);
   localparam int R_ADDR_W = ADDR_W - LANE_W;
   localparam int ROWS     = 1 << R_ADDR_W;

   // each row is a packed set of narrow lanes, lane 0 in the low bits
   logic [RATIO-1:0][W_DATA_W-1:0] mem [ROWS];

   logic [R_ADDR_W-1:0] w_row;
   logic [LANE_W-1:0]   w_lane;

   // upper address bits pick the row, low bits pick the lane
   assign w_row  = w_addr[ADDR_W-1:LANE_W];
   assign w_lane = w_addr[LANE_W-1:0];

   // narrow write into a single lane
   always_ff @(posedge clk) begin
      if (w_en) begin
         mem[w_row][w_lane] <= w_data;
      end
   end

   // whole row out, one cycle after r_en
   always_ff @(posedge clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

/* source/fifo_level_counter.sv */
module fifo_level_counter (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               w_req,
   input  logic               w_en,
   input  logic               r_en,
   output packer_pkg::level_t level,
   output logic               empty,
   output logic               full,
   output logic               overflow
);

   import packer_pkg::*;

   level_t level_nxt;
   level_t w_incr;
   level_t r_decr;

   // one byte in per write, one word (four bytes) out per read
   assign w_incr = w_en ? level_t'(1) : '0;
   assign r_decr = r_en ? level_t'(BYTES_PER_WORD) : '0;

   assign level_nxt = level + w_incr - r_decr;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         level <= '0;
      end else begin
         level <= level_nxt;
      end
   end

   // a read needs a whole word present
   assign empty = level < level_t'(BYTES_PER_WORD);
   assign full  = level == level_t'(DEPTH);

   // sticky until reset, raised by any request that hits a full fifo
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         overflow <= 1'b0;
      end else if (w_req && full) begin
         overflow <= 1'b1;
      end
   end

   // level must stay within the byte depth
   a_level_bound: assert property (
      @(posedge clk) disable iff (!rst_n)
      level <= level_t'(DEPTH)
   );

   // reads come from the drain side and must never take more than is held
   a_no_underflow: assert property (
      @(posedge clk) disable iff (!rst_n)
      r_en |-> level >= level_t'(BYTES_PER_WORD)
   );

endmodule

/* source/fifo_sync_asym.sv */
module fifo_sync_asym (
   input  logic               clk,
   input  logic               rst_n,

   // write side, one byte per strobe
   input  logic               w_en,
   input  packer_pkg::byte_t  w_data,
   output logic               w_full,

   // read side, one word per strobe
   input  logic               r_en,
   output packer_pkg::word_t  r_data,
   output logic               r_empty,

   // status
   output packer_pkg::level_t level,
   output logic               overflow
);

   import packer_pkg::*;

   logic w_en_int;
   logic r_en_int;

   logic [ADDR_W-1:0]    w_addr;
   logic [RD_ADDR_W-1:0] r_addr;

   // the only place where the flags gate the enables
   assign w_en_int = w_en & ~w_full;
   assign r_en_int = r_en & ~r_empty;

   // byte address, wraps at the depth
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         w_addr <= '0;
      end else if (w_en_int) begin
         w_addr <= w_addr + 1'b1;
      end
   end

   // word address, wraps with the byte address
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_addr <= '0;
      end else if (r_en_int) begin
         r_addr <= r_addr + 1'b1;
      end
   end

   fifo_level_counter u_level (
      .clk      (clk),
      .rst_n    (rst_n),
      .w_req    (w_en),
      .w_en     (w_en_int),
      .r_en     (r_en_int),
      .level    (level),
      .empty    (r_empty),
      .full     (w_full),
      .overflow (overflow)
   );

   asym_ram_2p #(
      .W_DATA_W (BYTE_W),
      .R_DATA_W (WORD_W),
      .ADDR_W   (ADDR_W)
   ) u_ram (
      .clk    (clk),
      .w_en   (w_en_int),
      .w_addr (w_addr),
      .w_data (w_data),
      .r_en   (r_en_int),
      .r_addr (r_addr),
      .r_data (r_data)
   );

endmodule

/* source/burst_drain_fsm.sv */
module burst_drain_fsm (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  flush,
   input  packer_pkg::level_t    level,
   input  logic                  r_empty,
   input  packer_pkg::word_t     r_data,
   output logic                  r_en,
   output logic                  out_strobe,
   output packer_pkg::out_beat_t out_beat
);

   import packer_pkg::*;

   typedef enum logic {
      IDLE,
      BURST
   } state_t;

   state_t     state;
   logic       flush_pend;
   logic       start;
   logic       last_rd;
   logic       last_q;
   level_t     level_words;
   burst_cnt_t burst_len;
   burst_cnt_t words_left;

   // whole words currently held
   assign level_words = level >> $clog2(BYTES_PER_WORD);

   // capped at one burst
   assign burst_len = (level_words >= level_t'(BURST_WORDS)) ?
                      burst_cnt_t'(BURST_WORDS) : burst_cnt_t'(level_words);

   // a full burst is buffered, or a flush asks for the remaining words
   assign start = (state == IDLE) &&
                  ((level >= level_t'(BURST_BYTES)) ||
                   (flush_pend && level >= level_t'(BYTES_PER_WORD)));

   assign r_en    = (state == BURST);
   assign last_rd = r_en && (words_left == burst_cnt_t'(1));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= IDLE;
         words_left <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  state      <= BURST;
                  words_left <= burst_len;
               end
            end
            BURST: begin
               words_left <= words_left - 1'b1;
               // always pass through idle before the next burst
               if (last_rd) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // held until only a partial word is left
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         flush_pend <= 1'b0;
      end else if (flush) begin
         flush_pend <= 1'b1;
      end else if (state == IDLE && level < level_t'(BYTES_PER_WORD)) begin
         flush_pend <= 1'b0;
      end
   end

   // ram data lags the read by one cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_strobe <= 1'b0;
         last_q     <= 1'b0;
      end else begin
         out_strobe <= r_en;
         last_q     <= last_rd;
      end
   end

   assign out_beat = '{data: r_data, last: last_q};

   // burst length is taken from the level, so a read never meets an empty fifo
   a_no_empty_read: assert property (
      @(posedge clk) disable iff (!rst_n)
      r_en |-> !r_empty
   );

endmodule

/* source/burst_packer_top.sv */
module burst_packer_top (
   input  logic                  clk,
   input  logic                  rst_n,

   // producer side
   input  logic                  in_strobe,
   input  packer_pkg::byte_t     in_byte,
   input  logic                  flush,

   // word output
   output logic                  out_strobe,
   output packer_pkg::out_beat_t out_beat,

   // sticky drop flag
   output logic                  overflow
);

   import packer_pkg::*;

   logic   r_en;
   logic   r_empty;
   word_t  r_data;
   level_t level;

   // bytes go straight into the fifo, full drops are counted inside
   fifo_sync_asym u_fifo (
      .clk      (clk),
      .rst_n    (rst_n),
      .w_en     (in_strobe),
      .w_data   (in_byte),
      .w_full   (),
      .r_en     (r_en),
      .r_data   (r_data),
      .r_empty  (r_empty),
      .level    (level),
      .overflow (overflow)
   );

   // decides when and how many words to pull
   burst_drain_fsm u_drain (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .level      (level),
      .r_empty    (r_empty),
      .r_data     (r_data),
      .r_en       (r_en),
      .out_strobe (out_strobe),
      .out_beat   (out_beat)
   );

endmodule

/* testbench/tb_burst_packer.sv */
module tb_burst_packer;

   timeunit 1ns;
   timeprecision 1ps;

   import packer_pkg::*;

   localparam bit [31:0] SEED        = 32'h8042d5f8;
   localparam string     STIM_FILE   = "testbench/burst_stimulus.txt";
   localparam int        DRAIN_LIMIT = 200;

   bit        clk;
   logic      rst_n;
   logic      in_strobe;
   byte_t     in_byte;
   logic      flush;
   logic      out_strobe;
   out_beat_t out_beat;
   logic      overflow;

   // reference model state, bytes in fifo order and one last flag per read
   byte_t ref_q[$];
   bit    last_q[$];
   int    m_level;
   int    m_left;
   bit    m_busy;
   bit    m_pend;
   bit    m_ovf;
   bit    drained = 1'b1;

   int    words_seen   = 0;
   int    beat_errs    = 0;
   int    beat_checks  = 0;
   int    err_cnt      = 0;
   int    check_cnt    = 0;
   int    test_cnt     = 0;
   int    limit_cycles = 0;
   bit    limit_ready  = 1'b0;
   string cur_test     = "reset";

   always #4 clk = ~clk;

   burst_packer_top u_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_strobe  (in_strobe),
      .in_byte    (in_byte),
      .flush      (flush),
      .out_strobe (out_strobe),
      .out_beat   (out_beat),
      .overflow   (overflow)
   );

   // drain rules stepped on the same edge as the dut
   always @(posedge clk) begin
      bit accept;
      bit start;
      bit pend_nxt;
      if (!rst_n) begin
         m_level = 0;
         m_left  = 0;
         m_busy  = 1'b0;
         m_pend  = 1'b0;
         m_ovf   = 1'b0;
         ref_q.delete();
         last_q.delete();
      end else begin
         accept   = in_strobe && (m_level < DEPTH);
         start    = !m_busy && ((m_level >= BURST_BYTES) ||
                                (m_pend && m_level >= BYTES_PER_WORD));
         pend_nxt = flush ? 1'b1 :
                    ((!m_busy && m_level < BYTES_PER_WORD) ? 1'b0 : m_pend);
         if (in_strobe && !accept) begin
            m_ovf = 1'b1;
         end
         if (accept) begin
            ref_q.push_back(in_byte);
         end
         if (m_busy) begin
            last_q.push_back(m_left == 1);
            m_left  = m_left - 1;
            m_busy  = (m_left != 0);
            m_level = m_level - BYTES_PER_WORD;
         end else if (start) begin
            m_busy = 1'b1;
            m_left = (m_level / BYTES_PER_WORD < BURST_WORDS) ?
                     m_level / BYTES_PER_WORD : BURST_WORDS;
         end
         if (accept) begin
            m_level = m_level + 1;
         end
         m_pend = pend_nxt;
      end
   end

   // outputs are registered, so the falling edge sees them settled
   always @(negedge clk) begin
      out_beat_t exp_beat;
      if (out_strobe === 1'b1) begin
         words_seen = words_seen + 1;
         if (last_q.size() == 0) begin
            $display("%s: a word came out with no read behind it (data %h)",
                     cur_test, out_beat.data);
            beat_errs = beat_errs + 1;
         end else if (ref_q.size() < BYTES_PER_WORD) begin
            $display("%s: a word came out before four bytes were written", cur_test);
            beat_errs = beat_errs + 1;
            void'(last_q.pop_front());
         end else begin
            exp_beat.last = last_q.pop_front();
            // first byte in goes to the low lane
            for (int i = 0; i < BYTES_PER_WORD; i++) begin
               exp_beat.data[i*BYTE_W +: BYTE_W] = ref_q.pop_front();
            end
            check_beat(cur_test, exp_beat, out_beat);
         end
      end
      drained = (last_q.size() == 0) && !m_busy && (m_level < BURST_BYTES) &&
                !(m_pend && m_level >= BYTES_PER_WORD);
   end

   task automatic check_beat(input string name, input out_beat_t exp, input out_beat_t act);
      beat_checks = beat_checks + 1;
      if (act !== exp) begin
         beat_errs = beat_errs + 1;
         $display("Error: %s word expected data %h last %b, actual data %h last %b",
                  name, exp.data, exp.last, act.data, act.last);
      end
   endtask

   task automatic check_flag(input string name, input string what,
                             input logic exp, input logic act);
      check_cnt = check_cnt + 1;
      if (act !== exp) begin
         err_cnt = err_cnt + 1;
         $display("Error: %s %s expected %b actual %b", name, what, exp, act);
      end
   endtask

   task automatic check_count(input string name, input string what, input int exp, input int act);
      check_cnt = check_cnt + 1;
      if (act != exp) begin
         err_cnt = err_cnt + 1;
         $display("Error: %s %s expected %0d actual %0d", name, what, exp, act);
      end
   endtask

   task automatic send_byte(input byte_t b);
      @(negedge clk);
      in_strobe = 1'b1;
      in_byte   = b;
   endtask

   task automatic release_inputs();
      @(negedge clk);
      in_strobe = 1'b0;
      flush     = 1'b0;
   endtask

   task automatic pulse_flush();
      @(negedge clk);
      flush = 1'b1;
      release_inputs();
   endtask

   task automatic wait_drained(input string name);
      int guard;
      guard = 0;
      @(posedge clk);
      while (!drained && guard < DRAIN_LIMIT) begin
         @(posedge clk);
         guard = guard + 1;
      end
      if (!drained) begin
         $display("%s: words still missing after %0d cycles", name, DRAIN_LIMIT);
         err_cnt = err_cnt + 1;
      end
   endtask

   // total byte count of the file, sizes the watchdog
   task automatic count_bytes(output int total);
      int    fd;
      int    a;
      string line;
      string cmd;
      total = 0;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         return;
      end
      while ($fgets(line, fd) != 0) begin
         if ($sscanf(line, "%s %d", cmd, a) == 2 && (cmd == "write" || cmd == "rand")) begin
            total = total + a;
         end
      end
      $fclose(fd);
   endtask

   task automatic run_stimulus();
      int    fd;
      int    a;
      int    b;
      int    words_start;
      int    errs_start;
      string line;
      string cmd;
      words_start = 0;
      errs_start  = 0;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("could not open %s for reading", STIM_FILE);
         err_cnt = err_cnt + 1;
         return;
      end
      while ($fgets(line, fd) != 0) begin
         a = 0;
         b = 0;
         if ($sscanf(line, "%s", cmd) < 1 || cmd == "#") begin
            continue;
         end
         if (cmd == "test") begin
            void'($sscanf(line, "%s %s", cmd, cur_test));
            @(posedge clk);
            words_start = words_seen;
            errs_start  = err_cnt + beat_errs;
         end else if (cmd == "write") begin
            void'($sscanf(line, "%s %d %h", cmd, a, b));
            for (int i = 0; i < a; i++) begin
               send_byte(byte_t'(b + i));
            end
            release_inputs();
         end else if (cmd == "rand") begin
            void'($sscanf(line, "%s %d", cmd, a));
            for (int i = 0; i < a; i++) begin
               send_byte(byte_t'($urandom));
            end
            release_inputs();
         end else if (cmd == "idle") begin
            void'($sscanf(line, "%s %d", cmd, a));
            repeat (a) @(negedge clk);
         end else if (cmd == "flush") begin
            pulse_flush();
         end else if (cmd == "ovf") begin
            void'($sscanf(line, "%s %d", cmd, a));
            @(negedge clk);
            if (m_ovf != (a != 0)) begin
               $display("%s: stimulus expects overflow %0d but the model predicts %0d",
                        cur_test, a, m_ovf);
               err_cnt = err_cnt + 1;
            end
            check_flag(cur_test, "overflow", logic'(a), overflow);
         end else if (cmd == "end") begin
            void'($sscanf(line, "%s %d", cmd, a));
            wait_drained(cur_test);
            check_count(cur_test, "words", a, words_seen - words_start);
            test_cnt = test_cnt + 1;
            $display("%s: %0d words, %0d errors", cur_test, words_seen - words_start,
                     err_cnt + beat_errs - errs_start);
         end else begin
            $display("unknown stimulus command %s", cmd);
            err_cnt = err_cnt + 1;
         end
      end
      $fclose(fd);
   endtask

   initial begin
      int total;
      rst_n     = 1'b0;
      in_strobe = 1'b0;
      in_byte   = '0;
      flush     = 1'b0;
      void'($urandom(SEED));
      count_bytes(total);
      limit_cycles = 200 * total + 2000;
      limit_ready  = 1'b1;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_flag("reset", "out_strobe", 1'b0, out_strobe);
      check_flag("reset", "overflow", 1'b0, overflow);
      run_stimulus();
      $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt + beat_checks,
               err_cnt + beat_errs);
      if (err_cnt + beat_errs == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // watchdog sized from the stimulus byte count
   initial begin
      wait (limit_ready);
      repeat (limit_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
      $display("Test failed");
      $finish;
   end

endmodule

/* testbench/burst_stimulus.txt */
# one command per line, fields split by spaces
# cmd    arg1                      arg2
# test   name
# write  byte count                first byte in hex, later bytes count up
# rand   byte count                bytes come from $urandom
# idle   cycles
# flush
# ovf    expected overflow, 0 or 1
# end    expected word count       waits until the drain is quiet

test reset_state
idle 20
ovf 0
end 0

test single_burst
write 16 10
idle 8
end 4

test sustained_stream
rand 48
end 12

test flush_remainder
write 10 40
flush
end 2

test flush_leftover
write 2 4a
flush
end 1

# the drain empties four bytes per cycle, so one byte per cycle never fills the fifo
test overflow
write 80 80
ovf 0
idle 10
ovf 0
end 20

/* tb.f */
source/packer_pkg.sv
source/asym_ram_2p.sv
source/fifo_level_counter.sv
source/fifo_sync_asym.sv
source/burst_drain_fsm.sv
source/burst_packer_top.sv
testbench/tb_burst_packer.sv

/* Makefile */
# Verilator build and run for the burst packer testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f tb.f --top-module tb_burst_packer \
		-Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	@if grep -qx "Test passed" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
